/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  // Major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_LOAD     = 7'b0000011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_IMM      = 7'b0010011;
  localparam opcode_t OP_OP       = 7'b0110011;
  localparam opcode_t OP_FENCE    = 7'b0001111;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;
  localparam opcode_t OP_LOAD_FP  = 7'b0000111; // FLW, FLD
  localparam opcode_t OP_STORE_FP = 7'b0100111; // FSW, FSD
  localparam opcode_t OP_MADD     = 7'b1000011;
  localparam opcode_t OP_MSUB     = 7'b1000111;
  localparam opcode_t OP_NMSUB    = 7'b1001011;
  localparam opcode_t OP_NMADD    = 7'b1001111;
  localparam opcode_t OP_OP_FP    = 7'b1010011; // Remaining FP computational ops

  // Integer ALU operation
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Write-back source
  typedef logic [2:0] wb_sel_t;

  localparam wb_sel_t WB_ALU   = 3'd0;
  localparam wb_sel_t WB_MEM   = 3'd1;
  localparam wb_sel_t WB_PC4   = 3'd2; // Link address
  localparam wb_sel_t WB_CSR   = 3'd3;
  localparam wb_sel_t WB_MDU   = 3'd4; // Multiply/divide result
  localparam wb_sel_t WB_FPINT = 3'd6; // FPU integer result

  // Immediate format
  typedef logic [2:0] imm_sel_t;

  localparam imm_sel_t IMM_I = 3'd0;
  localparam imm_sel_t IMM_S = 3'd1;
  localparam imm_sel_t IMM_B = 3'd2;
  localparam imm_sel_t IMM_U = 3'd3;
  localparam imm_sel_t IMM_J = 3'd4;

  // FPU operation
  typedef logic [4:0] fp_op_t;

  localparam fp_op_t FP_ADD    = 5'b00000;
  localparam fp_op_t FP_SUB    = 5'b00001;
  localparam fp_op_t FP_MUL    = 5'b00010;
  localparam fp_op_t FP_DIV    = 5'b00011;
  localparam fp_op_t FP_SQRT   = 5'b00100;
  localparam fp_op_t FP_SGNJ   = 5'b00101;
  localparam fp_op_t FP_SGNJN  = 5'b00110;
  localparam fp_op_t FP_SGNJX  = 5'b00111;
  localparam fp_op_t FP_MIN    = 5'b01000;
  localparam fp_op_t FP_MAX    = 5'b01001;
  localparam fp_op_t FP_CVT    = 5'b01010;
  localparam fp_op_t FP_CMP    = 5'b01011;
  localparam fp_op_t FP_CLASS  = 5'b01100;
  localparam fp_op_t FP_FMA    = 5'b01101;
  localparam fp_op_t FP_FMSUB  = 5'b01110;
  localparam fp_op_t FP_FNMSUB = 5'b01111;
  localparam fp_op_t FP_FNMADD = 5'b10000;
  localparam fp_op_t FP_MV_XW  = 5'b10001; // FMV.X.W
  localparam fp_op_t FP_MV_WX  = 5'b10010; // FMV.W.X

  localparam logic [2:0] RM_DYN        = 3'b111;     // Rounding mode taken from fcsr
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension under OP
  localparam logic [6:0] FUNCT7_SFENCE = 7'b0001001; // SFENCE.VMA

  // Fixed SYSTEM encodings with funct3 = 000
  localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_SRET   = 32'h1020_0073;
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;

  // Control bundle handed to execute
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    alu_op_t  alu_control;
    logic     alu_src;           // 1 selects immediate
    wb_sel_t  wb_sel;
    imm_sel_t imm_sel;
    logic     csr_we;
    logic     csr_src;           // 1 selects uimm
    logic     mul_div_en;
    logic [2:0] mul_div_op;
    logic     fp_reg_write;
    logic     int_reg_write_fp;  // FP op that writes the integer file
    logic     fp_mem_op;
    logic     fp_alu_en;
    fp_op_t   fp_alu_op;
    logic     fp_use_dynamic_rm;
    logic     illegal_inst;
  } ctrl_t;

  localparam ctrl_t CTRL_NONE = '0; // Bubble, enables nothing

endpackage

`default_nettype wire

/* common/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One decoder's result as seen by the merge
interface ctrl_if import ctrl_pkg::*; ();

  logic  hit;     // Decoder owns this opcode
  logic  illegal; // Owned but field combination invalid
  ctrl_t ctrl;    // CTRL_NONE whenever hit is low

  modport decoder (
    output hit,
    output illegal,
    output ctrl
  );

  modport merge (
    input hit,
    input illegal,
    input ctrl
  );

endinterface

`default_nettype wire

/* decode/int_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module int_decode import ctrl_pkg::*; (
  input wire [31:0] instr,
  ctrl_if.decoder   dec
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       hit;
  ctrl_t      c;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ALU op from funct3 plus instr[30]; SUB only exists for register form
  function automatic alu_op_t alu_op_f(input logic [2:0] f3, input logic f7_b5,
                                       input logic is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_b5 ? ALU_SRA : ALU_SRL; // SRAI uses the same bit
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    hit = 1'b0;
    c   = CTRL_NONE;
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        hit         = 1'b1;
        c.reg_write = 1'b1;
        c.alu_src   = 1'b1; // Immediate plus zero or PC
        c.imm_sel   = IMM_U;
      end
      OP_JAL: begin
        hit         = 1'b1;
        c.reg_write = 1'b1;
        c.jump      = 1'b1;
        c.wb_sel    = WB_PC4;
        c.imm_sel   = IMM_J;
      end
      OP_JALR: begin
        hit         = 1'b1;
        c.reg_write = 1'b1;
        c.jump      = 1'b1;
        c.alu_src   = 1'b1; // Target is rs1 + imm
        c.wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        hit           = 1'b1;
        c.branch      = 1'b1;
        c.alu_control = ALU_SUB; // Compare by subtraction
        c.imm_sel     = IMM_B;
      end
      OP_LOAD: begin
        hit         = 1'b1;
        c.reg_write = 1'b1;
        c.mem_read  = 1'b1;
        c.alu_src   = 1'b1;
        c.wb_sel    = WB_MEM;
      end
      OP_STORE: begin
        hit         = 1'b1;
        c.mem_write = 1'b1;
        c.alu_src   = 1'b1;
        c.imm_sel   = IMM_S;
      end
      OP_IMM: begin
        hit           = 1'b1;
        c.reg_write   = 1'b1;
        c.alu_src     = 1'b1;
        c.alu_control = alu_op_f(funct3, funct7[5], 1'b0);
      end
      OP_OP: begin
        hit         = 1'b1;
        c.reg_write = 1'b1;
        if (funct7 == FUNCT7_MULDIV) begin
          c.mul_div_en = 1'b1;
          c.mul_div_op = funct3; // MUL..REMU in funct3 order
          c.wb_sel     = WB_MDU;
        end else begin
          c.alu_control = alu_op_f(funct3, funct7[5], 1'b1);
        end
      end
      default: ; // Not an integer opcode
    endcase
  end

  assign dec.hit     = hit;
  assign dec.illegal = 1'b0; // Every integer field combination decodes
  assign dec.ctrl    = c;

endmodule

`default_nettype wire

/* decode/fp_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_decode import ctrl_pkg::*; (
  input wire [31:0] instr,
  ctrl_if.decoder   dec
);

  opcode_t    opcode;
  logic [2:0] funct3;   // rm for arithmetic groups
  logic [6:0] funct7;
  logic       dyn_rm;
  logic       hit;
  logic       illegal;
  ctrl_t      c;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign dyn_rm = (funct3 == RM_DYN);

  always_comb begin
    hit     = 1'b0;
    illegal = 1'b0;
    c       = CTRL_NONE;
    case (opcode)
      OP_LOAD_FP: begin
        hit            = 1'b1;
        c.fp_reg_write = 1'b1;
        c.mem_read     = 1'b1;
        c.fp_mem_op    = 1'b1;
        c.alu_src      = 1'b1; // Address is rs1 + imm_i
        c.wb_sel       = WB_MEM;
      end
      OP_STORE_FP: begin
        hit         = 1'b1;
        c.mem_write = 1'b1;
        c.fp_mem_op = 1'b1;
        c.alu_src   = 1'b1;
        c.imm_sel   = IMM_S;
      end
      OP_MADD, OP_MSUB, OP_NMSUB, OP_NMADD: begin
        hit                 = 1'b1;
        c.fp_reg_write      = 1'b1;
        c.fp_alu_en         = 1'b1;
        c.fp_use_dynamic_rm = dyn_rm;
        case (opcode)
          OP_MSUB:  c.fp_alu_op = FP_FMSUB;
          OP_NMSUB: c.fp_alu_op = FP_FNMSUB;
          OP_NMADD: c.fp_alu_op = FP_FNMADD;
          default:  c.fp_alu_op = FP_FMA;
        endcase
      end
      OP_OP_FP: begin
        hit         = 1'b1;
        c.fp_alu_en = 1'b1;
        case (funct7[6:2])
          5'b00000, 5'b00001, 5'b00010, 5'b00011, 5'b01011: begin
            c.fp_reg_write      = 1'b1; // ADD SUB MUL DIV SQRT
            c.fp_use_dynamic_rm = dyn_rm;
            case (funct7[6:2])
              5'b00001: c.fp_alu_op = FP_SUB;
              5'b00010: c.fp_alu_op = FP_MUL;
              5'b00011: c.fp_alu_op = FP_DIV;
              5'b01011: c.fp_alu_op = FP_SQRT;
              default:  c.fp_alu_op = FP_ADD;
            endcase
          end
          5'b00100: begin // Sign injection
            c.fp_reg_write = 1'b1;
            case (funct3)
              3'b000:  c.fp_alu_op = FP_SGNJ;
              3'b001:  c.fp_alu_op = FP_SGNJN;
              3'b010:  c.fp_alu_op = FP_SGNJX;
              default: illegal = 1'b1;
            endcase
          end
          5'b00101: begin
            c.fp_reg_write = 1'b1;
            c.fp_alu_op    = funct3[0] ? FP_MAX : FP_MIN;
          end
          5'b01000, 5'b11000, 5'b11001, 5'b11010, 5'b11011: begin
            c.fp_alu_op         = FP_CVT;
            c.fp_use_dynamic_rm = dyn_rm;
            if (funct7[6] && !funct7[3]) begin // FP to integer
              c.reg_write        = 1'b1;
              c.int_reg_write_fp = 1'b1;
              c.wb_sel           = WB_FPINT;
            end else begin
              c.fp_reg_write = 1'b1; // Int to FP, or S/D conversion
            end
          end
          5'b10100: begin // FEQ FLT FLE
            c.reg_write        = 1'b1;
            c.int_reg_write_fp = 1'b1;
            c.wb_sel           = WB_FPINT;
            c.fp_alu_op        = FP_CMP;
          end
          5'b11100: begin
            c.reg_write        = 1'b1;
            c.int_reg_write_fp = 1'b1;
            c.wb_sel           = WB_FPINT;
            case (funct3)
              3'b000:  c.fp_alu_op = FP_MV_XW;
              3'b001:  c.fp_alu_op = FP_CLASS;
              default: illegal = 1'b1;
            endcase
          end
          5'b11110: begin
            c.fp_reg_write = 1'b1;
            c.fp_alu_op    = FP_MV_WX;
          end
          default: illegal = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  assign dec.hit     = hit;
  assign dec.illegal = illegal;
  assign dec.ctrl    = c;

endmodule

`default_nettype wire

/* decode/sys_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_decode import ctrl_pkg::*; (
  input wire [31:0] instr,
  ctrl_if.decoder   dec
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       is_sfence;
  logic       is_priv;   // Recognized funct3 = 000 encoding
  logic       hit;
  logic       illegal;
  ctrl_t      c;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // rs1 and rs2 are free operands, rd must be x0
  assign is_sfence = (instr[31:25] == FUNCT7_SFENCE) && (instr[11:7] == 5'd0);
  assign is_priv   = (instr == INSTR_ECALL) || (instr == INSTR_EBREAK)
                  || (instr == INSTR_MRET) || (instr == INSTR_SRET) || is_sfence;

  always_comb begin
    hit     = 1'b0;
    illegal = 1'b0;
    c       = CTRL_NONE;
    case (opcode)
      OP_FENCE: hit = 1'b1; // Ordering only, nothing to enable
      OP_SYSTEM: begin
        hit = 1'b1;
        if (funct3 != 3'b000) begin // CSRRW..CSRRCI
          c.reg_write = 1'b1;
          c.wb_sel    = WB_CSR;
          c.csr_we    = 1'b1;        // Write suppression happens downstream
          c.csr_src   = funct3[2];
        end else begin
          illegal = !is_priv;        // Traps and returns handled later in pipe
        end
      end
      default: ;
    endcase
  end

  assign dec.hit     = hit;
  assign dec.illegal = illegal;
  assign dec.ctrl    = c;

endmodule

`default_nettype wire

/* hw/control_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module control_stage import ctrl_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        instr_valid,
  input  wire [31:0] instr,
  input  wire        stall,        // Back-pressure from execute
  output logic       out_valid,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write,
  output logic       branch,
  output logic       jump,
  output alu_op_t    alu_control,
  output logic       alu_src,
  output wb_sel_t    wb_sel,
  output imm_sel_t   imm_sel,
  output logic       csr_we,
  output logic       csr_src,
  output logic       mul_div_en,
  output logic [2:0] mul_div_op,
  output logic       fp_reg_write,
  output logic       int_reg_write_fp,
  output logic       fp_mem_op,
  output logic       fp_alu_en,
  output fp_op_t     fp_alu_op,
  output logic       fp_use_dynamic_rm,
  output logic       illegal_inst
);

  ctrl_if int_bus ();
  ctrl_if fp_bus ();
  ctrl_if sys_bus ();

  ctrl_t merged;
  ctrl_t ctrl_q;   // ID/EX control register
  logic  valid_q;

  int_decode u_int_decode (.instr(instr), .dec(int_bus));
  fp_decode  u_fp_decode  (.instr(instr), .dec(fp_bus));
  sys_decode u_sys_decode (.instr(instr), .dec(sys_bus));

  // Claims are disjoint, priority order only fixes the mux shape
  always_comb begin
    merged = CTRL_NONE;
    if (int_bus.hit) begin
      merged              = int_bus.ctrl;
      merged.illegal_inst = int_bus.illegal;
    end else if (fp_bus.hit) begin
      merged              = fp_bus.ctrl;
      merged.illegal_inst = fp_bus.illegal;
    end else if (sys_bus.hit) begin
      merged              = sys_bus.ctrl;
      merged.illegal_inst = sys_bus.illegal;
    end else begin
      merged.illegal_inst = 1'b1; // Unclaimed opcode
    end
    if (merged.illegal_inst) begin
      merged              = CTRL_NONE; // Illegal never enables a unit
      merged.illegal_inst = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q  <= CTRL_NONE;
      valid_q <= 1'b0;
    end else if (!stall) begin
      ctrl_q  <= instr_valid ? merged : CTRL_NONE; // Bubble when no instruction
      valid_q <= instr_valid;
    end
  end

  assign out_valid         = valid_q;
  assign reg_write         = ctrl_q.reg_write;
  assign mem_read          = ctrl_q.mem_read;
  assign mem_write         = ctrl_q.mem_write;
  assign branch            = ctrl_q.branch;
  assign jump              = ctrl_q.jump;
  assign alu_control       = ctrl_q.alu_control;
  assign alu_src           = ctrl_q.alu_src;
  assign wb_sel            = ctrl_q.wb_sel;
  assign imm_sel           = ctrl_q.imm_sel;
  assign csr_we            = ctrl_q.csr_we;
  assign csr_src           = ctrl_q.csr_src;
  assign mul_div_en        = ctrl_q.mul_div_en;
  assign mul_div_op        = ctrl_q.mul_div_op;
  assign fp_reg_write      = ctrl_q.fp_reg_write;
  assign int_reg_write_fp  = ctrl_q.int_reg_write_fp;
  assign fp_mem_op         = ctrl_q.fp_mem_op;
  assign fp_alu_en         = ctrl_q.fp_alu_en;
  assign fp_alu_op         = ctrl_q.fp_alu_op;
  assign fp_use_dynamic_rm = ctrl_q.fp_use_dynamic_rm;
  assign illegal_inst      = ctrl_q.illegal_inst;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 2; // 4 ns clock
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release just after an edge so no flop sees rst_n move at the edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_control_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_control_stage import ctrl_pkg::*; ();

  localparam int NUM_RANDOM   = 2000;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int TIMEOUT_NS   = NUM_RANDOM * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] word;  // Instruction behind this entry
    logic        valid;
    ctrl_t       ctrl;
  } expect_t;

  // ALU op per funct3 before the instr[30] variants
  localparam alu_op_t BASE_ALU [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                       ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

  // Claimed opcodes with extra weight on the busy ones and then unclaimed codes
  localparam opcode_t OPCODES [32] = '{
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM,
    OP_OP, OP_FENCE, OP_SYSTEM, OP_LOAD_FP, OP_STORE_FP, OP_MADD, OP_MSUB, OP_NMSUB,
    OP_NMADD, OP_OP_FP, OP_OP, OP_OP, OP_IMM, OP_OP_FP, OP_OP_FP, OP_OP_FP,
    OP_SYSTEM, OP_SYSTEM,
    7'b0011011,  // OP-IMM-32
    7'b0111011,  // OP-32
    7'b0101111,  // AMO
    7'b0000000, 7'b1111111, 7'b1011011
  };

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        stall;
  logic        out_valid;
  logic        reg_write, mem_read, mem_write, branch, jump;
  alu_op_t     alu_control;
  logic        alu_src;
  wb_sel_t     wb_sel;
  imm_sel_t    imm_sel;
  logic        csr_we, csr_src;
  logic        mul_div_en;
  logic [2:0]  mul_div_op;
  logic        fp_reg_write, int_reg_write_fp, fp_mem_op, fp_alu_en;
  fp_op_t      fp_alu_op;
  logic        fp_use_dynamic_rm;
  logic        illegal_inst;

  ctrl_t       got;         // Output ports gathered in bundle order
  expect_t     exp_q [$];
  expect_t     held;        // What the output register should show now
  integer      seed   = 32'h9319_e50e;
  int          errors = 0;
  int          checks = 0;

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  control_stage DUT (.*);

  assign got = {reg_write, mem_read, mem_write, branch, jump, alu_control, alu_src,
                wb_sel, imm_sel, csr_we, csr_src, mul_div_en, mul_div_op, fp_reg_write,
                int_reg_write_fp, fp_mem_op, fp_alu_en, fp_alu_op, fp_use_dynamic_rm,
                illegal_inst};

  // Reference decode built from the ISA field rules
  function automatic ctrl_t expect_ctrl(input logic [31:0] w);
    ctrl_t      e;
    logic [2:0] f3;
    logic [4:0] f5;
    logic       bad;
    logic       to_int;    // FP op with an integer destination
    logic       rm_group;  // Group that honours the rm field
    e        = CTRL_NONE;
    f3       = w[14:12];
    f5       = w[31:27];
    bad      = 1'b0;
    to_int   = 1'b0;
    rm_group = 1'b0;
    case (w[6:0])
      OP_LUI, OP_AUIPC: begin
        e.reg_write = 1'b1;
        e.alu_src   = 1'b1;
        e.imm_sel   = IMM_U;
      end
      OP_JAL, OP_JALR: begin
        e.reg_write = 1'b1;
        e.jump      = 1'b1;
        e.wb_sel    = WB_PC4;
        e.alu_src   = (w[6:0] == OP_JALR);       // rs1 + imm target
        e.imm_sel   = (w[6:0] == OP_JAL) ? IMM_J : IMM_I;
      end
      OP_BRANCH: begin
        e.branch      = 1'b1;
        e.alu_control = ALU_SUB;
        e.imm_sel     = IMM_B;
      end
      OP_LOAD, OP_LOAD_FP: begin
        e.mem_read     = 1'b1;
        e.alu_src      = 1'b1;
        e.wb_sel       = WB_MEM;
        e.fp_mem_op    = (w[6:0] == OP_LOAD_FP);
        e.reg_write    = !e.fp_mem_op;
        e.fp_reg_write = e.fp_mem_op;
      end
      OP_STORE, OP_STORE_FP: begin
        e.mem_write = 1'b1;
        e.alu_src   = 1'b1;
        e.imm_sel   = IMM_S;
        e.fp_mem_op = (w[6:0] == OP_STORE_FP);
      end
      OP_IMM, OP_OP: begin
        e.reg_write   = 1'b1;
        e.alu_src     = (w[6:0] == OP_IMM);
        e.alu_control = BASE_ALU[f3];
        if (w[30] && f3 == 3'b101) e.alu_control = ALU_SRA;
        if (w[30] && f3 == 3'b000 && !e.alu_src) e.alu_control = ALU_SUB; // No SUBI
        if (!e.alu_src && w[31:25] == 7'b0000001) begin
          e.alu_control = ALU_ADD;
          e.mul_div_en  = 1'b1;
          e.mul_div_op  = f3;
          e.wb_sel      = WB_MDU;
        end
      end
      OP_MADD, OP_MSUB, OP_NMSUB, OP_NMADD: begin
        e.fp_reg_write = 1'b1;
        e.fp_alu_en    = 1'b1;
        e.fp_alu_op    = FP_FMA + fp_op_t'(w[3:2]); // Opcode bits 3:2 pick the variant
        rm_group       = 1'b1;
      end
      OP_OP_FP: begin
        e.fp_alu_en    = 1'b1;
        e.fp_reg_write = 1'b1;
        case (f5)
          5'b00000, 5'b00001, 5'b00010, 5'b00011: begin
            e.fp_alu_op = FP_ADD + fp_op_t'(f5[1:0]); // ADD SUB MUL DIV
            rm_group    = 1'b1;
          end
          5'b01011: begin
            e.fp_alu_op = FP_SQRT;
            rm_group    = 1'b1;
          end
          5'b00100: begin
            e.fp_alu_op = FP_SGNJ + fp_op_t'(f3);
            bad         = (f3 > 3'd2);
          end
          5'b00101: e.fp_alu_op = f3[0] ? FP_MAX : FP_MIN;
          5'b01000, 5'b11000, 5'b11001, 5'b11010, 5'b11011: begin
            e.fp_alu_op = FP_CVT;
            rm_group    = 1'b1;
            to_int      = (f5 == 5'b11000) || (f5 == 5'b11001);
          end
          5'b10100: begin
            e.fp_alu_op = FP_CMP;
            to_int      = 1'b1;
          end
          5'b11100: begin
            e.fp_alu_op = f3[0] ? FP_CLASS : FP_MV_XW;
            to_int      = 1'b1;
            bad         = (f3 > 3'd1);
          end
          5'b11110: e.fp_alu_op = FP_MV_WX;
          default:  bad = 1'b1;
        endcase
      end
      OP_FENCE: ;
      OP_SYSTEM: begin
        if (f3 != 3'b000) begin
          e.reg_write = 1'b1;
          e.wb_sel    = WB_CSR;
          e.csr_we    = 1'b1;
          e.csr_src   = f3[2];  // Immediate forms
        end else begin
          // ECALL, EBREAK, MRET, SRET, SFENCE.VMA with rd = x0
          bad = !(w == 32'h0000_0073 || w == 32'h0010_0073 || w == 32'h3020_0073
                  || w == 32'h1020_0073 || (w[31:25] == 7'b0001001 && w[11:7] == 5'd0));
        end
      end
      default: bad = 1'b1;
    endcase
    if (to_int) begin
      e.fp_reg_write     = 1'b0;
      e.reg_write        = 1'b1;
      e.int_reg_write_fp = 1'b1;
      e.wb_sel           = WB_FPINT;
    end
    if (rm_group) e.fp_use_dynamic_rm = (f3 == 3'b111);
    if (bad) begin
      e              = CTRL_NONE;
      e.illegal_inst = 1'b1;
    end
    return e;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [4:0]  pick;
    logic [2:0]  bias;
    w      = $random(seed);
    pick   = 5'($random(seed));
    bias   = 3'($random(seed));
    w[6:0] = OPCODES[pick];
    if (w[6:0] == OP_OP) begin
      case (bias[1:0])
        2'd0:    w[31:25] = 7'b0000000;
        2'd1:    w[31:25] = 7'b0100000; // SUB, SRA
        2'd2:    w[31:25] = 7'b0000001; // M extension
        default: ;
      endcase
    end
    if (bias[2] && (w[6:4] == 3'b100 || w[6:0] == OP_OP_FP)) w[14:12] = 3'b111; // Dynamic rm
    return w;
  endfunction

  task automatic check_outputs();
    if (exp_q.size() > 0) held = exp_q.pop_front();
    checks++;
    assert ({out_valid, got} === {held.valid, held.ctrl}) else begin
      errors++;
      $display("[ERROR] %0t: instr %h gave valid %b ctrl %h, expected valid %b ctrl %h",
               $time, held.word, out_valid, got, held.valid, held.ctrl);
    end
  endtask

  // Checks the previous load and drives the next inputs for one clock
  task automatic present(input logic [31:0] word, input logic valid, input logic hold);
    expect_t entry;
    @(posedge clk);
    #1;
    check_outputs();
    instr       = word;
    instr_valid = valid;
    stall       = hold;
    entry       = '{word, valid, valid ? expect_ctrl(word) : CTRL_NONE};
    if (!hold) exp_q.push_back(entry); // Stalled edge loads nothing
  endtask

  initial begin
    instr_valid = 1'b0;
    instr       = 32'h0;
    stall       = 1'b0;
    held        = '0;
    @(posedge clk); // First edge, reset already applied
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      if (rst_n !== 1'b1) begin
        checks++;
        assert ({out_valid, got} === '0) else begin
          errors++;
          $display("[ERROR] %0t: outputs not clear during reset", $time);
        end
      end
    end
    present({12'h000, 5'd0, 3'b000, 5'd0, OP_SYSTEM}, 1'b1, 1'b0);  // ECALL
    present({12'h001, 5'd0, 3'b000, 5'd0, OP_SYSTEM}, 1'b1, 1'b0);  // EBREAK
    present({12'h302, 5'd0, 3'b000, 5'd0, OP_SYSTEM}, 1'b1, 1'b0);  // MRET
    present({12'h102, 5'd0, 3'b000, 5'd0, OP_SYSTEM}, 1'b1, 1'b0);  // SRET
    present({7'b0001001, 5'd3, 5'd10, 3'b000, 5'd0, OP_SYSTEM}, 1'b1, 1'b0); // SFENCE.VMA
    present({7'b0001001, 5'd3, 5'd10, 3'b000, 5'd1, OP_SYSTEM}, 1'b1, 1'b0); // rd != x0
    present({12'h300, 5'd5, 3'b101, 5'd7, OP_SYSTEM}, 1'b1, 1'b0);  // CSRRWI
    present({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OP_OP}, 1'b1, 1'b0); // MUL
    present({7'b0000001, 5'd2, 5'd1, 3'b101, 5'd3, OP_OP}, 1'b1, 1'b0); // DIVU
    // Hold under stall, then release with a fresh instruction
    present({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, OP_OP}, 1'b1, 1'b0); // SUB
    present(random_instr(), 1'b1, 1'b1);
    present(random_instr(), 1'b0, 1'b1);
    present(random_instr(), 1'b1, 1'b1);
    present({12'h7ff, 5'd4, 3'b111, 5'd5, OP_IMM}, 1'b1, 1'b0);     // ANDI
    present(32'h0, 1'b0, 1'b0);                                      // Bubble
    for (int i = 0; i < NUM_RANDOM; i++) begin
      present(random_instr(), ($random(seed) & 7) != 0, ($random(seed) & 3) == 0);
    end
    present(32'h0, 1'b0, 1'b0);
    @(posedge clk);
    #1;
    check_outputs();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* control_stage.f */
common/ctrl_pkg.sv
common/ctrl_if.sv
decode/int_decode.sv
decode/fp_decode.sv
decode/sys_decode.sv
hw/control_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_control_stage.sv

/* Makefile */
# Sources taken from the file list so the binary tracks every listed file
SRCS := $(shell grep '\.sv$$' control_stage.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_control_stage: control_stage.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_control_stage -f control_stage.f

run: obj_dir/Vtb_control_stage
	./obj_dir/Vtb_control_stage | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
